// ==== hw/rv_core_pkg.sv ====
// ********************
// core-wide constants, opcodes, format and ALU enums
// instruction word union
// ********************
package rv_core_pkg;

    localparam int XLEN = 32;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE  // illegal or unsupported opcode
    } inst_fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // one 32-bit word, five ways of slicing it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_u;

endpackage

// ==== hw/decode_if.sv ====
// ********************
// decoded instruction fields, decode to regs and execute
// ********************
`timescale 1ns/1ps

interface decode_if import rv_core_pkg::*; ();

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;     // sign-extended per format
    inst_fmt_e       fmt;
    alu_op_e         alu_op;

    modport producer (
        output opcode, funct3, rd, rs1, rs2, imm, fmt, alu_op
    );

    // rd is the write address
    modport regs (
        input rd, rs1, rs2
    );

    modport consumer (
        input opcode, funct3, rd, rs1, rs2, imm, fmt, alu_op
    );

endinterface

// ==== hw/fetch_unit.sv ====
// ********************
// PC register, fetch FSM, instruction register
// ********************
`timescale 1ns/1ps

module fetch_unit import rv_core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_valid,
    input  logic [XLEN-1:0] imem_rdata,
    input  logic            jump_en,
    input  logic [XLEN-1:0] jump_target,
    output logic            imem_req,
    output logic [XLEN-1:0] imem_addr,
    output logic [XLEN-1:0] pc,
    output inst_u           inst,
    output logic            exec_en
);

    localparam logic ST_REQ  = 1'b0;
    localparam logic ST_EXEC = 1'b1;

    logic state;
    logic fetch_done;  // response accepted this cycle

    assign fetch_done = imem_req && imem_valid;
    assign exec_en    = (state == ST_EXEC);
    assign imem_addr  = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ST_REQ;
            imem_req <= 1'b0;
            pc       <= RESET_PC;
        end else begin
            unique case (state)
                ST_REQ: begin
                    if (fetch_done) begin
                        state    <= ST_EXEC;
                        imem_req <= 1'b0;
                    end else begin
                        imem_req <= 1'b1;  // also the first request after reset
                    end
                end
                ST_EXEC: begin
                    state    <= ST_REQ;
                    imem_req <= 1'b1;
                    pc       <= jump_en ? jump_target : pc + XLEN'(4);
                end
                default: state <= ST_REQ;
            endcase
        end
    end

    // captured word, held through exec
    always_ff @(posedge clk) begin
        if (fetch_done) inst <= imem_rdata;
    end

endmodule

// ==== hw/decode_unit.sv ====
// ********************
// opcode classification, immediates, ALU op select
// ********************
`timescale 1ns/1ps

module decode_unit import rv_core_pkg::*; (
    input inst_u     inst,
    decode_if.producer dec
);

    // register fields sit at the same bits in every format
    assign dec.opcode = inst.r_fmt.opcode;
    assign dec.funct3 = inst.r_fmt.funct3;
    assign dec.rd     = inst.r_fmt.rd;
    assign dec.rs1    = inst.r_fmt.rs1;
    assign dec.rs2    = inst.r_fmt.rs2;

    always_comb begin
        unique case (inst.r_fmt.opcode)
            OPC_OP:               dec.fmt = FMT_R;
            OPC_OP_IMM, OPC_JALR: dec.fmt = FMT_I;
            OPC_BRANCH:           dec.fmt = FMT_B;
            OPC_LUI, OPC_AUIPC:   dec.fmt = FMT_U;
            OPC_JAL:              dec.fmt = FMT_J;
            default:              dec.fmt = FMT_NONE;
        endcase
    end

    always_comb begin
        unique case (dec.fmt)
            FMT_I: dec.imm = {{(XLEN-12){inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            FMT_B: dec.imm = {{(XLEN-12){inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                              inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            FMT_U: dec.imm = {inst.u_fmt.imm_31_12, 12'b0};
            FMT_J: dec.imm = {{(XLEN-20){inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12,
                              inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            default: dec.imm = '0;
        endcase
    end

    // jumps, branches and U types all want a plain add
    always_comb begin
        dec.alu_op = ALU_ADD;
        if (inst.r_fmt.opcode == OPC_OP || inst.r_fmt.opcode == OPC_OP_IMM) begin
            unique case (inst.r_fmt.funct3)
                3'b000: begin
                    if (dec.fmt == FMT_R && inst.r_fmt.funct7 == 7'b0100000) begin
                        dec.alu_op = ALU_SUB;
                    end
                end
                3'b001: dec.alu_op = ALU_SLL;
                3'b010: dec.alu_op = ALU_SLT;
                3'b011: dec.alu_op = ALU_SLTU;
                3'b100: dec.alu_op = ALU_XOR;
                // bit 30 picks arithmetic shift, shamt form too
                3'b101: dec.alu_op = inst.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: dec.alu_op = ALU_OR;
                3'b111: dec.alu_op = ALU_AND;
                default: dec.alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

// ==== hw/reg_file.sv ====
// ********************
// 32 x 32 register file, 2R 1W
// ********************
`timescale 1ns/1ps

module reg_file import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    decode_if.regs          dec,
    input  logic            exec_en,
    input  logic            we,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (exec_en && we && dec.rd != 5'd0) begin  // x0 never written
            regs[dec.rd] <= wdata;
        end
    end

    assign rdata1 = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
    assign rdata2 = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

endmodule

// ==== hw/alu.sv ====
// ********************
// integer ALU, ten ops
// ********************
`timescale 1ns/1ps

module alu import rv_core_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        unique case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

// ==== hw/execute_unit.sv ====
// ********************
// operand mux, branch compare, jump target, writeback data
// ********************
`timescale 1ns/1ps

module execute_unit import rv_core_pkg::*; (
    decode_if.consumer      dec,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rdata1,
    input  logic [XLEN-1:0] rdata2,
    output logic            jump_en,
    output logic [XLEN-1:0] jump_target,
    output logic            wb_we,
    output logic [XLEN-1:0] wb_wdata
);

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] pc_plus4;
    logic            is_jalr;
    logic            taken;

    assign pc_plus4 = pc + XLEN'(4);
    assign is_jalr  = (dec.fmt == FMT_I) && (dec.opcode == OPC_JALR);

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    always_comb begin
        unique case (dec.fmt)
            FMT_R: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
            FMT_I: begin
                alu_a = rdata1;
                alu_b = dec.imm;
            end
            FMT_U: begin
                alu_a = (dec.opcode == OPC_LUI) ? '0 : pc;  // LUI or AUIPC
                alu_b = dec.imm;
            end
            FMT_B, FMT_J: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
        endcase
    end

    always_comb begin
        unique case (dec.funct3)
            3'b000:  taken = (rdata1 == rdata2);                   // beq
            3'b001:  taken = (rdata1 != rdata2);                   // bne
            3'b100:  taken = ($signed(rdata1) < $signed(rdata2));  // blt
            3'b101:  taken = ($signed(rdata1) >= $signed(rdata2)); // bge
            3'b110:  taken = (rdata1 < rdata2);                    // bltu
            3'b111:  taken = (rdata1 >= rdata2);                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        if (dec.fmt == FMT_J) begin
            jump_en = 1'b1;
        end else if (is_jalr) begin
            jump_en     = 1'b1;
            jump_target = {alu_result[XLEN-1:1], 1'b0};
        end else if (dec.fmt == FMT_B) begin
            jump_en = taken;
        end
    end

    // link address for both jumps
    assign wb_wdata = (dec.fmt == FMT_J || is_jalr) ? pc_plus4 : alu_result;
    assign wb_we    = (dec.fmt != FMT_B) && (dec.fmt != FMT_NONE);

endmodule

// ==== hw/rv_core_top.sv ====
// ********************
// RV32I multi-cycle core, top level
// ********************
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    output logic            imem_req,
    output logic [XLEN-1:0] imem_addr,
    input  logic            imem_valid,
    input  logic [XLEN-1:0] imem_rdata,
    output logic            retire_valid,
    output logic            retire_we,
    output logic [4:0]      retire_rd,
    output logic [XLEN-1:0] retire_wdata
);

    logic [XLEN-1:0] pc;
    inst_u           inst;
    logic            exec_en;
    logic            jump_en;
    logic [XLEN-1:0] jump_target;
    logic            wb_we;
    logic [XLEN-1:0] wb_wdata;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;

    decode_if dec_bus ();

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .reset       (reset),
        .imem_valid  (imem_valid),
        .imem_rdata  (imem_rdata),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .pc          (pc),
        .inst        (inst),
        .exec_en     (exec_en)
    );

    decode_unit u_decode (
        .inst (inst),
        .dec  (dec_bus.producer)
    );

    reg_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .dec     (dec_bus.regs),
        .exec_en (exec_en),
        .we      (wb_we),
        .wdata   (wb_wdata),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    execute_unit u_exec (
        .dec         (dec_bus.consumer),
        .pc          (pc),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .wb_we       (wb_we),
        .wb_wdata    (wb_wdata)
    );

    // one retire per exec cycle
    assign retire_valid = exec_en;
    assign retire_we    = exec_en && wb_we;  // qualified, inst is stale outside exec
    assign retire_rd    = dec_bus.rd;
    assign retire_wdata = wb_wdata;

endmodule

// ==== verif/rv_core_assert.sv ====
// ********************
// fetch and retire protocol assertions, bound into the core top
// ********************
`timescale 1ns/1ps

module rv_core_assert import rv_core_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic            imem_req,
    input logic [XLEN-1:0] imem_addr,
    input logic            imem_valid,
    input logic            retire_valid
);

    int fail_count = 0;  // read by the testbench at the end

    // request held with a steady address until the response
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        imem_req && !imem_valid |=> imem_req && $stable(imem_addr))
        else begin
            $error("imem_addr or imem_req changed while a request was pending");
            fail_count++;
        end

    retire_after_fetch: assert property (@(posedge clk) disable iff (reset)
        imem_req && imem_valid |=> retire_valid ##1 !retire_valid)
        else begin
            $error("retire_valid did not follow the accepted fetch for one cycle");
            fail_count++;
        end

    retire_has_fetch: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(imem_req && imem_valid))
        else begin
            $error("retire_valid without an accepted fetch on the previous edge");
            fail_count++;
        end

    addr_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_req |-> imem_addr[1:0] == 2'b00)
        else begin
            $error("imem_addr is not word aligned");
            fail_count++;
        end

    req_retire_excl: assert property (@(posedge clk) disable iff (reset)
        !(imem_req && retire_valid))
        else begin
            $error("imem_req and retire_valid high in the same cycle");
            fail_count++;
        end

endmodule

// ==== verif/rv_core_checker.sv ====
// ********************
// trace-based checker for fetch addresses and retire events
// ********************
`timescale 1ns/1ps

module rv_core_checker import rv_core_pkg::*; #(
    parameter int MAX_INST = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_req,
    input  logic [XLEN-1:0] imem_addr,
    input  logic            imem_valid,
    input  logic            retire_valid,
    input  logic            retire_we,
    input  logic [4:0]      retire_rd,
    input  logic [XLEN-1:0] retire_wdata,
    output int              error_count,
    output int              retire_count,
    output logic            done
);

    logic [XLEN-1:0] trace [0:6*MAX_INST-1];  // six words per instruction
    int              n_inst;
    int              fetch_count;

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
            error_count++;
        end
    endtask

    initial begin
        error_count  = 0;
        retire_count = 0;
        fetch_count  = 0;
        // odd fill, no word-aligned fetch address can match it
        for (int k = 0; k < 6*MAX_INST; k++) begin
            trace[k] = ~XLEN'(k);
        end
        $readmemh("verif/core_trace.txt", trace);
        n_inst = 0;
        while (n_inst < MAX_INST && trace[6*n_inst] !== ~XLEN'(6*n_inst)) begin
            n_inst++;
        end
    end

    // sampled mid-cycle away from both edges
    always @(negedge clk) begin
        if (!reset) begin
            if (imem_req && imem_valid && fetch_count < n_inst) begin
                check_value("imem_addr", trace[6*fetch_count], imem_addr);
                fetch_count++;
            end
            if (retire_valid) begin
                if (retire_count >= n_inst) begin
                    $display("extra retire after the last trace entry at %0t", $time);
                    error_count++;
                end else begin
                    check_value("retire_we", trace[6*retire_count+3], XLEN'(retire_we));
                    if (trace[6*retire_count+3][0]) begin
                        check_value("retire_rd", trace[6*retire_count+4], XLEN'(retire_rd));
                        check_value("retire_wdata", trace[6*retire_count+5], retire_wdata);
                    end
                end
                retire_count++;
            end
        end
    end

    assign done = (n_inst > 0) && (retire_count >= n_inst);

endmodule

// ==== verif/tb_rv_core.sv ====
// ********************
// testbench top, clock, reset and trace-driven imem responder
// ********************
`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*; ();

    localparam int              MAX_INST = 64;
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    logic            clk;
    logic            reset;
    logic            imem_req;
    logic [XLEN-1:0] imem_addr;
    logic            imem_valid;
    logic [XLEN-1:0] imem_rdata;
    logic            retire_valid;
    logic            retire_we;
    logic [4:0]      retire_rd;
    logic [XLEN-1:0] retire_wdata;
    int              error_count;
    int              retire_count;
    logic            done;

    logic [XLEN-1:0] trace [0:6*MAX_INST-1];
    int              n_inst;
    int              cycle_limit;
    int              cycle_count;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_valid   (imem_valid),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata)
    );

    rv_core_checker #(
        .MAX_INST (MAX_INST)
    ) u_checker (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_valid   (imem_valid),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .error_count  (error_count),
        .retire_count (retire_count),
        .done         (done)
    );

    bind rv_core_top rv_core_assert u_assert (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_valid   (imem_valid),
        .retire_valid (retire_valid)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d instructions retired",
                     cycle_count, retire_count, n_inst);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic wait_for_request();
        @(posedge clk);
        while (!imem_req) @(posedge clk);
    endtask

    // one-cycle valid pulse after delay edges from the one that saw the request
    task automatic send_response(input logic [XLEN-1:0] word, input int delay);
        repeat (delay) @(posedge clk);
        #1;
        imem_valid = 1'b1;
        imem_rdata = word;
        @(posedge clk);
        #1;
        imem_valid = 1'b0;
    endtask

    initial begin
        int jitter;
        clk         = 1'b0;
        reset       = 1'b1;
        imem_valid  = 1'b0;
        imem_rdata  = '0;
        cycle_count = 0;
        void'($urandom(32'he0db3560));
        // odd fill, no word-aligned fetch address can match it
        for (int k = 0; k < 6*MAX_INST; k++) begin
            trace[k] = ~XLEN'(k);
        end
        $readmemh("verif/core_trace.txt", trace);
        n_inst = 0;
        while (n_inst < MAX_INST && trace[6*n_inst] !== ~XLEN'(6*n_inst)) begin
            n_inst++;
        end
        cycle_limit = 8 + 20;
        for (int k = 0; k < n_inst; k++) begin
            cycle_limit += int'(trace[6*k+2]) + 1 + 4;
        end

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < n_inst; i++) begin
            wait_for_request();
            jitter = $urandom_range(1, 0);
            send_response(trace[6*i+1], int'(trace[6*i+2]) + jitter);
        end
        wait (done);
        repeat (4) @(posedge clk);  // room for a stray retire

        $display("%0d value errors, %0d assertion failures, %0d of %0d instructions retired",
                 error_count, i_dut.u_assert.fail_count, retire_count, n_inst);
        if (error_count == 0 && i_dut.u_assert.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/rv_core_pkg.sv
hw/decode_if.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/execute_unit.sv
hw/rv_core_top.sv
verif/rv_core_assert.sv
verif/rv_core_checker.sv
verif/tb_rv_core.sv

// ==== verif/core_trace.txt ====
// columns: fetch addr, inst word, extra delay cycles, retire_we, retire_rd, retire_wdata
// rd and wdata are only compared when retire_we is 1
80000000 ffb00093 0 1 01 fffffffb
80000004 00300113 1 1 02 00000003
80000008 402081b3 0 1 03 fffffff8
8000000c 4020d233 2 1 04 ffffffff
80000010 0020d2b3 0 1 05 1fffffff
80000014 0020a333 3 1 06 00000001
80000018 0020b3b3 0 1 07 00000000
8000001c 00700013 1 1 00 00000007
80000020 00200433 0 1 08 00000003
80000024 0f00c493 2 1 09 ffffff0b
80000028 7ff4f513 0 1 0a 0000070b
8000002c 00411593 1 1 0b 00000030
80000030 00a5e633 0 1 0c 0000073b
80000034 123456b7 3 1 0d 12345000
80000038 00001717 0 1 0e 80001038
8000003c 008007ef 1 1 0f 80000040
80000044 0000057f 2 0 00 00000000
80000048 00000817 0 1 10 80000048
8000004c 011808e7 1 1 11 80000050
80000058 00810463 0 0 00 00000000
80000060 00208463 2 0 00 00000000
80000064 00209463 0 0 00 00000000
8000006c 00811463 1 0 00 00000000
80000070 0020c463 3 0 00 00000000
80000078 0020e463 0 0 00 00000000
8000007c 0020d463 1 0 00 00000000
80000080 0020f463 0 0 00 00000000
80000088 00114463 2 0 00 00000000
8000008c 00116463 0 0 00 00000000
80000094 00115463 1 0 00 00000000
8000009c 00117463 0 0 00 00000000
800000a0 fff60913 3 1 12 0000073a
